//--- cnn_pkg.sv
package cnn_pkg;

    // array sizes
    localparam int DEPTH_NB   = 4;
    localparam int GROUP_NB   = 2;
    localparam int IMG_WIDTH  = 16;
    localparam int KER_WIDTH  = 16;
    localparam int NUM_WIDTH  = IMG_WIDTH + KER_WIDTH + 1;
    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // pipeline latencies in cycles
    localparam int MAC_LAT = 4;
    localparam int ADD_LAT = 2;
    localparam int OPS_LAT = 3;

    typedef logic signed [IMG_WIDTH-1:0] img_t;
    typedef logic signed [KER_WIDTH-1:0] ker_t;
    typedef logic signed [NUM_WIDTH-1:0] num_t;

    typedef img_t       [GROUP_NB-1:0] image_bus_t;
    typedef ker_t       [GROUP_NB-1:0] ker_group_t;
    typedef num_t       [GROUP_NB-1:0] num_group_t;
    typedef ker_group_t [DEPTH_NB-1:0] kernel_bus_t;
    typedef ker_t       [DEPTH_NB-1:0] bias_bus_t;
    typedef img_t       [DEPTH_NB-1:0] result_bus_t;

    typedef logic [CFG_DWIDTH-1:0] cfg_data_t;
    typedef logic [CFG_AWIDTH-1:0] cfg_addr_t;
    typedef logic [7:0]            pool_cnt_t;
    typedef logic [7:0]            shift_t;

    // config word layout
    localparam cfg_addr_t CFG_LAYERS     = cfg_addr_t'(3);
    localparam int        CFG_BYPASS_BIT = 16;
    localparam int        CFG_POOL_LSB   = 8;
    localparam int        CFG_SHIFT_LSB  = 0;

    // saturation limits of a result pixel
    localparam num_t PIX_MAX = num_t'((1 <<< (IMG_WIDTH - 1)) - 1);
    localparam num_t PIX_MIN = num_t'(-(1 <<< (IMG_WIDTH - 1)));

    typedef enum logic [1:0] {
        UP_RESET,
        UP_READY,
        UP_DONE,
        UP_CLEAR
    } up_state_t;

    typedef enum logic [2:0] {
        DN_RESET,
        DN_READY,
        DN_ADD,
        DN_POOL,
        DN_OPS,
        DN_CLEAR
    } dn_state_t;

endpackage

//--- group_mac.sv
`timescale 1ns/1ps

module group_mac (
    input  logic                   clk,
    input  logic                   clear,
    input  cnn_pkg::image_bus_t    image,
    input  cnn_pkg::ker_group_t    kernel,
    input  logic                   kernel_en,
    output cnn_pkg::num_group_t    acc
);

    cnn_pkg::num_group_t prod;
    logic                prod_val;

    // product stage, one multiplier per pixel
    always_ff @(posedge clk) begin
        for (int g = 0; g < cnn_pkg::GROUP_NB; g++) begin
            prod[g] <= image[g] * kernel[g];
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            prod_val <= 1'b0;
        end else begin
            prod_val <= kernel_en;
        end
    end

    // accumulate stage
    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (prod_val) begin
            for (int g = 0; g < cnn_pkg::GROUP_NB; g++) begin
                acc[g] <= acc[g] + prod[g];
            end
        end
    end

endmodule

//--- group_add.sv
`timescale 1ns/1ps

module group_add (
    input  logic                   clk,
    input  cnn_pkg::num_group_t    group_sum,
    output cnn_pkg::num_t          sum
);

    cnn_pkg::num_t pair_q [cnn_pkg::GROUP_NB/2];
    cnn_pkg::num_t tree_sum;

    // first level adds neighbouring accumulators
    always_ff @(posedge clk) begin
        for (int p = 0; p < cnn_pkg::GROUP_NB/2; p++) begin
            pair_q[p] <= group_sum[2*p] + group_sum[2*p+1];
        end
    end

    always_comb begin
        tree_sum = '0;
        for (int p = 0; p < cnn_pkg::GROUP_NB/2; p++) begin
            tree_sum = tree_sum + pair_q[p];
        end
    end

    always_ff @(posedge clk) begin
        sum <= tree_sum;
    end

endmodule

//--- pool.sv
`timescale 1ns/1ps

module pool (
    input  logic             clk,
    input  logic             restart,
    input  logic             en,
    input  cnn_pkg::num_t    sum,
    output cnn_pkg::num_t    pooled
);

    logic first;

    // set until the first window of a frame has been taken
    always_ff @(posedge clk) begin
        if (restart) begin
            first <= 1'b1;
        end else if (en) begin
            first <= 1'b0;
        end
    end

    // signed running maximum
    always_ff @(posedge clk) begin
        if (en && (first || (sum > pooled))) begin
            pooled <= sum;
        end
    end

endmodule

//--- lane_ops.sv
`timescale 1ns/1ps

module lane_ops (
    input  logic              clk,
    input  cnn_pkg::ker_t     bias,
    input  logic              bypass,
    input  cnn_pkg::shift_t   shift,
    input  cnn_pkg::num_t     pooled,
    output cnn_pkg::img_t     pixel
);

    cnn_pkg::num_t biased;
    cnn_pkg::num_t rectified;
    cnn_pkg::num_t scaled;

    // stage 1: bias add
    always_ff @(posedge clk) begin
        biased <= pooled + cnn_pkg::num_t'(bias);
    end

    // stage 2: relu, skipped when bypass is set
    always_ff @(posedge clk) begin
        if (!bypass && biased[cnn_pkg::NUM_WIDTH-1]) begin
            rectified <= '0;
        end else begin
            rectified <= biased;
        end
    end

    assign scaled = rectified >>> shift;

    // stage 3: rescale and clamp to pixel range
    always_ff @(posedge clk) begin
        if (scaled > cnn_pkg::PIX_MAX) begin
            pixel <= cnn_pkg::img_t'(cnn_pkg::PIX_MAX);
        end else if (scaled < cnn_pkg::PIX_MIN) begin
            pixel <= cnn_pkg::img_t'(cnn_pkg::PIX_MIN);
        end else begin
            pixel <= cnn_pkg::img_t'(scaled);
        end
    end

endmodule

//--- layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  cnn_pkg::cfg_data_t   cfg_data,
    input  cnn_pkg::cfg_addr_t   cfg_addr,
    input  logic                 cfg_valid,
    input  logic                 image_val,
    input  logic                 image_last,
    input  logic                 result_rdy,
    output logic                 image_rdy,
    output logic                 kernel_rdy,
    output logic                 result_val,
    output logic                 mac_clear,
    output logic                 hold_en,
    output logic                 pool_restart,
    output logic                 pool_en,
    output logic                 result_en,
    output logic                 bypass,
    output cnn_pkg::shift_t      shift
);

    cnn_pkg::up_state_t          up_state;
    cnn_pkg::up_state_t          up_next;
    cnn_pkg::dn_state_t          dn_state;
    cnn_pkg::dn_state_t          dn_next;
    cnn_pkg::pool_cnt_t          pool_nb;
    cnn_pkg::pool_cnt_t          pool_cnt;
    logic [cnn_pkg::MAC_LAT-1:0] mac_vld;
    logic [cnn_pkg::ADD_LAT-1:0] add_vld;
    logic [cnn_pkg::OPS_LAT-1:0] ops_vld;
    logic                        last_beat;
    logic                        handoff;
    logic                        last_window;

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass  <= 1'b0;
            pool_nb <= '0;
            shift   <= '0;
        end else if (cfg_valid && (cfg_addr == cnn_pkg::CFG_LAYERS)) begin
            bypass  <= cfg_data[cnn_pkg::CFG_BYPASS_BIT];
            pool_nb <= cfg_data[cnn_pkg::CFG_POOL_LSB +: $bits(cnn_pkg::pool_cnt_t)];
            shift   <= cfg_data[cnn_pkg::CFG_SHIFT_LSB +: $bits(cnn_pkg::shift_t)];
        end
    end

    assign image_rdy    = (up_state == cnn_pkg::UP_READY);
    assign last_beat    = image_val && image_rdy && image_last;
    assign mac_clear    = (up_state == cnn_pkg::UP_RESET);
    assign hold_en      = mac_vld[cnn_pkg::MAC_LAT-1];
    // frame moves from the MAC side to post-processing
    assign handoff      = (up_state == cnn_pkg::UP_CLEAR) && (dn_state == cnn_pkg::DN_READY);
    assign pool_restart = (dn_state == cnn_pkg::DN_RESET);
    assign pool_en      = add_vld[cnn_pkg::ADD_LAT-1];
    assign last_window  = (dn_state == cnn_pkg::DN_POOL) && (pool_cnt >= pool_nb);
    assign result_en    = ops_vld[cnn_pkg::OPS_LAT-1];
    assign result_val   = (dn_state == cnn_pkg::DN_CLEAR);

    // upstream machine, MAC phase
    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= cnn_pkg::UP_RESET;
        end else begin
            up_state <= up_next;
        end
    end

    always_comb begin
        up_next = up_state;
        case (up_state)
            cnn_pkg::UP_RESET: up_next = cnn_pkg::UP_READY;
            cnn_pkg::UP_READY: if (last_beat) up_next = cnn_pkg::UP_DONE;
            cnn_pkg::UP_DONE:  if (hold_en) up_next = cnn_pkg::UP_CLEAR;
            cnn_pkg::UP_CLEAR: if (dn_state == cnn_pkg::DN_READY) up_next = cnn_pkg::UP_RESET;
            default:           up_next = cnn_pkg::UP_RESET;
        endcase
    end

    // downstream machine, add, pool and output ops
    always_ff @(posedge clk) begin
        if (rst) begin
            dn_state <= cnn_pkg::DN_RESET;
        end else begin
            dn_state <= dn_next;
        end
    end

    always_comb begin
        dn_next = dn_state;
        case (dn_state)
            cnn_pkg::DN_RESET: dn_next = cnn_pkg::DN_READY;
            cnn_pkg::DN_READY: if (handoff) dn_next = cnn_pkg::DN_ADD;
            cnn_pkg::DN_ADD:   if (pool_en) dn_next = cnn_pkg::DN_POOL;
            cnn_pkg::DN_POOL: begin
                if (last_window) begin
                    dn_next = cnn_pkg::DN_OPS;
                end else begin
                    dn_next = cnn_pkg::DN_READY;
                end
            end
            cnn_pkg::DN_OPS:   if (result_en) dn_next = cnn_pkg::DN_CLEAR;
            cnn_pkg::DN_CLEAR: if (result_rdy) dn_next = cnn_pkg::DN_RESET;
            default:           dn_next = cnn_pkg::DN_RESET;
        endcase
    end

    // weights are sampled the cycle after each image beat
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            mac_vld    <= '0;
            add_vld    <= '0;
            ops_vld    <= '0;
        end else begin
            kernel_rdy <= image_val && image_rdy;
            mac_vld    <= {mac_vld[cnn_pkg::MAC_LAT-2:0], last_beat};
            add_vld    <= {add_vld[cnn_pkg::ADD_LAT-2:0], handoff};
            ops_vld    <= {ops_vld[cnn_pkg::OPS_LAT-2:0], last_window};
        end
    end

    // windows pooled so far in this frame
    always_ff @(posedge clk) begin
        if (rst || (dn_state == cnn_pkg::DN_RESET)) begin
            pool_cnt <= '0;
        end else if (dn_state == cnn_pkg::DN_POOL) begin
            pool_cnt <= pool_cnt + 8'd1;
        end
    end

endmodule

//--- layers.sv
`timescale 1ns/1ps

module layers (
    input  logic                    clk,
    input  logic                    rst,
    input  cnn_pkg::cfg_data_t      cfg_data,
    input  cnn_pkg::cfg_addr_t      cfg_addr,
    input  logic                    cfg_valid,
    input  cnn_pkg::bias_bus_t      bias_bus,
    input  cnn_pkg::kernel_bus_t    kernel_bus,
    output logic                    kernel_rdy,
    input  cnn_pkg::image_bus_t     image_bus,
    input  logic                    image_last,
    input  logic                    image_val,
    output logic                    image_rdy,
    output cnn_pkg::result_bus_t    result_bus,
    output logic                    result_val,
    input  logic                    result_rdy
);

    logic                 mac_clear;
    logic                 hold_en;
    logic                 pool_restart;
    logic                 pool_en;
    logic                 result_en;
    logic                 bypass;
    cnn_pkg::shift_t      shift;
    cnn_pkg::image_bus_t  image_q;
    cnn_pkg::result_bus_t lane_pixels;

    layer_ctrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .cfg_data     (cfg_data),
        .cfg_addr     (cfg_addr),
        .cfg_valid    (cfg_valid),
        .image_val    (image_val),
        .image_last   (image_last),
        .result_rdy   (result_rdy),
        .image_rdy    (image_rdy),
        .kernel_rdy   (kernel_rdy),
        .result_val   (result_val),
        .mac_clear    (mac_clear),
        .hold_en      (hold_en),
        .pool_restart (pool_restart),
        .pool_en      (pool_en),
        .result_en    (result_en),
        .bypass       (bypass),
        .shift        (shift)
    );

    // pixels line up with kernel_rdy one cycle later
    always_ff @(posedge clk) begin
        image_q <= image_bus;
    end

    generate
        for (genvar i = 0; i < cnn_pkg::DEPTH_NB; i++) begin : lane
            cnn_pkg::num_group_t acc;
            cnn_pkg::num_group_t hold;
            cnn_pkg::num_t       sum;
            cnn_pkg::num_t       pooled;

            group_mac mac (
                .clk       (clk),
                .clear     (mac_clear),
                .image     (image_q),
                .kernel    (kernel_bus[i]),
                .kernel_en (kernel_rdy),
                .acc       (acc)
            );

            // frees the accumulators for the next frame
            always_ff @(posedge clk) begin
                if (hold_en) begin
                    hold <= acc;
                end
            end

            group_add adder (
                .clk       (clk),
                .group_sum (hold),
                .sum       (sum)
            );

            pool max_pool (
                .clk     (clk),
                .restart (pool_restart),
                .en      (pool_en),
                .sum     (sum),
                .pooled  (pooled)
            );

            lane_ops ops (
                .clk    (clk),
                .bias   (bias_bus[i]),
                .bypass (bypass),
                .shift  (shift),
                .pooled (pooled),
                .pixel  (lane_pixels[i])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (result_en) begin
            result_bus <= lane_pixels;
        end
    end

endmodule

//--- tb_layers.sv
`timescale 1ns/1ps

module tb_layers;

    localparam int     NUM_ROWS = 6;
    localparam longint PIX_HI   = (longint'(1) <<< (cnn_pkg::IMG_WIDTH - 1)) - 1;
    localparam longint PIX_LO   = -PIX_HI - 1;

    typedef struct packed {
        cnn_pkg::cfg_data_t cfg;
        logic [7:0]         beats;
        logic               fixed;
        logic [7:0]         stall;
        cnn_pkg::bias_bus_t bias;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst;
    cnn_pkg::cfg_data_t   cfg_data;
    cnn_pkg::cfg_addr_t   cfg_addr;
    logic                 cfg_valid;
    cnn_pkg::bias_bus_t   bias_bus;
    cnn_pkg::kernel_bus_t kernel_bus;
    logic                 kernel_rdy;
    cnn_pkg::image_bus_t  image_bus;
    logic                 image_last;
    logic                 image_val;
    logic                 image_rdy;
    cnn_pkg::result_bus_t result_bus;
    logic                 result_val;
    logic                 result_rdy;

    row_t        rows [NUM_ROWS];
    longint      win_sum [cnn_pkg::DEPTH_NB];
    bit          cur_bypass;
    int          cur_pool;
    int          cur_shift;
    longint      budget_ns = 0;
    logic        xfer_q = 1'b0;
    int unsigned seed = 32'h96a5_c336;

    layers uut (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .bias_bus   (bias_bus),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    always #50 clk = ~clk;

    task automatic check_result(input cnn_pkg::result_bus_t got, input cnn_pkg::result_bus_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: result_bus %h, expected %h", $time, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // every accepted beat must be answered by kernel_rdy in the following cycle
    always @(negedge clk) begin
        check_flag(kernel_rdy, xfer_q, "kernel_rdy");
        xfer_q = image_val && image_rdy;
    end

    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("Timeout: no result from the DUT within %0d ns", budget_ns);
        $display("Finished with errors");
        $fatal(1);
    end

    task automatic set_row(input int idx, input cnn_pkg::cfg_data_t cfg, input int beats,
                           input bit fixed, input int stall, input cnn_pkg::bias_bus_t bias);
        rows[idx].cfg   = cfg;
        rows[idx].beats = beats[7:0];
        rows[idx].fixed = fixed;
        rows[idx].stall = stall[7:0];
        rows[idx].bias  = bias;
    endtask

    // bias, relu, shift and clamp as the layer defines them
    function automatic cnn_pkg::img_t post_ops(input longint best, input longint bias,
                                               input bit bypass, input int shift);
        longint v;
        v = best + bias;
        if (!bypass && v < 0)
            v = 0;
        v = v >>> shift;
        if (v > PIX_HI)
            v = PIX_HI;
        else if (v < PIX_LO)
            v = PIX_LO;
        return cnn_pkg::img_t'(v);
    endfunction

    task automatic write_cfg(input row_t row);
        @(posedge clk);
        #1;
        cfg_data   = row.cfg;
        cfg_addr   = cnn_pkg::CFG_LAYERS;
        cfg_valid  = 1'b1;
        bias_bus   = row.bias;
        result_rdy = (row.stall == 0);
        cur_bypass = row.cfg[cnn_pkg::CFG_BYPASS_BIT];
        cur_pool   = row.cfg[cnn_pkg::CFG_POOL_LSB +: 8];
        cur_shift  = row.cfg[cnn_pkg::CFG_SHIFT_LSB +: 8];
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
    endtask

    task automatic send_beat(input cnn_pkg::image_bus_t img, input cnn_pkg::kernel_bus_t ker,
                             input bit last);
        image_bus  = img;
        image_last = last;
        image_val  = 1'b1;
        @(negedge clk);
        while (!image_rdy)
            @(negedge clk);
        @(posedge clk);
        #1;
        image_val  = 1'b0;
        image_last = 1'b0;
        kernel_bus = ker;
    endtask

    task automatic stream_window(input int beats, input bit fixed);
        cnn_pkg::image_bus_t  img;
        cnn_pkg::kernel_bus_t ker;
        int pix [cnn_pkg::GROUP_NB];
        int w;
        for (int d = 0; d < cnn_pkg::DEPTH_NB; d++)
            win_sum[d] = 0;
        for (int b = 0; b < beats; b++) begin
            for (int g = 0; g < cnn_pkg::GROUP_NB; g++) begin
                pix[g] = fixed ? 7 : int'($urandom_range(15)) - 8;
                img[g] = cnn_pkg::img_t'(pix[g]);
            end
            for (int d = 0; d < cnn_pkg::DEPTH_NB; d++) begin
                for (int g = 0; g < cnn_pkg::GROUP_NB; g++) begin
                    // fixed rows push each lane toward the sign of its bias
                    if (fixed)
                        w = bias_bus[d][cnn_pkg::KER_WIDTH-1] ? -7 : 7;
                    else
                        w = int'($urandom_range(15)) - 8;
                    ker[d][g] = cnn_pkg::ker_t'(w);
                    win_sum[d] += longint'(pix[g]) * longint'(w);
                end
            end
            send_beat(img, ker, b == beats - 1);
        end
    endtask

    task automatic run_frame(input int beats, input bit fixed, output cnn_pkg::result_bus_t exp);
        longint best [cnn_pkg::DEPTH_NB];
        for (int w = 0; w <= cur_pool; w++) begin
            stream_window(beats, fixed);
            for (int d = 0; d < cnn_pkg::DEPTH_NB; d++)
                if (w == 0 || win_sum[d] > best[d])
                    best[d] = win_sum[d];
        end
        for (int d = 0; d < cnn_pkg::DEPTH_NB; d++)
            exp[d] = post_ops(best[d], longint'($signed(bias_bus[d])), cur_bypass, cur_shift);
    endtask

    task automatic wait_result();
        @(negedge clk);
        while (!result_val)
            @(negedge clk);
    endtask

    task automatic take_result(input cnn_pkg::result_bus_t exp);
        wait_result();
        check_result(result_bus, exp);
        @(posedge clk);
        #1;
        @(negedge clk);
        check_flag(result_val, 1'b0, "result_val after transfer");
    endtask

    initial begin
        cnn_pkg::result_bus_t exp1;
        cnn_pkg::result_bus_t exp2;
        longint               cycles;
        rst        = 1'b1;
        cfg_data   = '0;
        cfg_addr   = '0;
        cfg_valid  = 1'b0;
        bias_bus   = '0;
        kernel_bus = '0;
        image_bus  = '0;
        image_last = 1'b0;
        image_val  = 1'b0;
        result_rdy = 1'b0;
        void'($urandom(seed));

        // cfg word, beats per window, fixed data, stall cycles, bias lane 3 down to 0
        set_row(0, 32'h0001_0000, 4, 0, 0, {16'sd100, -16'sd50, 16'sd25, 16'sd0});
        set_row(1, 32'h0000_0000, 3, 0, 0, {-16'sd2000, 16'sd2000, -16'sd1500, 16'sd1500});
        set_row(2, 32'h0001_0200, 5, 0, 0, {16'sd10, 16'sd20, 16'sd30, 16'sd40});
        set_row(3, 32'h0001_0003, 6, 0, 0, {-16'sd300, 16'sd300, -16'sd77, 16'sd77});
        set_row(4, 32'h0001_0000, 8, 1, 0, {16'sd32700, -16'sd32700, 16'sd32700, -16'sd32700});
        set_row(5, 32'h0000_0001, 2, 0, 6, {16'sd5, -16'sd5, 16'sd500, -16'sd500});

        cycles = 20;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycles += (rows[r].beats + 40) * (rows[r].cfg[cnn_pkg::CFG_POOL_LSB +: 8] + 1);
            cycles += rows[r].stall;
            if (rows[r].stall != 0)
                cycles += rows[r].beats + 40;
        end
        budget_ns = cycles * 100;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag(result_val, 1'b0, "result_val after reset");
        check_flag(image_rdy, 1'b0, "image_rdy during UP_RESET");
        @(negedge clk);
        check_flag(image_rdy, 1'b1, "image_rdy after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            write_cfg(rows[r]);
            run_frame(rows[r].beats, rows[r].fixed, exp1);
            if (rows[r].stall == 0) begin
                take_result(exp1);
            end else begin
                wait_result();
                check_result(result_bus, exp1);
                @(posedge clk);
                #1;
                // next frame completes upstream while the result is held
                run_frame(rows[r].beats, rows[r].fixed, exp2);
                repeat (rows[r].stall) begin
                    @(negedge clk);
                    check_flag(result_val, 1'b1, "result_val during stall");
                    check_result(result_bus, exp1);
                    check_flag(image_rdy, 1'b0, "image_rdy during stall");
                end
                @(posedge clk);
                #1;
                result_rdy = 1'b1;
                @(posedge clk);
                #1;
                take_result(exp2);
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sources.f
cnn_pkg.sv
group_mac.sv
group_add.sv
pool.sv
lane_ops.sv
layer_ctrl.sv
layers.sv
tb_layers.sv
